// File: design/pe_array_consts.svh
`ifndef PE_ARRAY_CONSTS_SVH
`define PE_ARRAY_CONSTS_SVH

// Datapath widths, signed
`define PE_DATA_WIDTH 16
`define PE_PSUM_WIDTH 32

// Array shape, also the filter size (rows by taps)
`define PE_NUM_ROW 3
`define PE_NUM_COL 3

// Ifmap row tag, rows 0 to 4 of one band
`define PE_TAG_WIDTH 3

// Configuration space
// weights live at 3*row + tap, one address above them pulses flush
`define PE_CFG_ADDR_WIDTH 4
`define PE_CFG_FLUSH_ADDR 9

`endif

// File: design/pe_array_pkg.sv
`include "pe_array_consts.svh"

package pe_array_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath types
    ////////////////////////////////////////////////////////////////////////////

    // One ifmap pixel or one filter weight
    typedef logic signed [`PE_DATA_WIDTH-1:0] pixel_t;

    // Partial sum carried up each column
    typedef logic signed [`PE_PSUM_WIDTH-1:0] psum_t;

    // Ifmap row number attached to each pixel
    typedef logic [`PE_TAG_WIDTH-1:0] tag_t;

    ////////////////////////////////////////////////////////////////////////////
    // Configuration types
    ////////////////////////////////////////////////////////////////////////////

    // Register address, 3*row + tap for weights
    typedef logic [`PE_CFG_ADDR_WIDTH-1:0] cfg_addr_t;

    // Three taps of one filter row, tap k at index k
    typedef pixel_t [`PE_NUM_COL-1:0] weight_row_t;

endpackage

// File: design/pe_config_regs.sv
`timescale 1ns/1ps
`include "pe_array_consts.svh"

module pe_config_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cfg_we,
    input  pe_array_pkg::cfg_addr_t   cfg_addr,
    input  pe_array_pkg::pixel_t      cfg_wdata,
    output pe_array_pkg::weight_row_t weights [`PE_NUM_ROW],
    output logic                      flush
);

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    logic flush_hit;
    logic wr_hit [`PE_NUM_ROW][`PE_NUM_COL];

    assign flush_hit = cfg_we &&
        (cfg_addr == pe_array_pkg::cfg_addr_t'(`PE_CFG_FLUSH_ADDR));

    // One strobe per weight register
    always_comb begin
        for (int i = 0; i < `PE_NUM_ROW; i++) begin
            for (int k = 0; k < `PE_NUM_COL; k++) begin
                wr_hit[i][k] = cfg_we &&
                    (cfg_addr == pe_array_pkg::cfg_addr_t'(i * `PE_NUM_COL + k));
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Weight register file
    ////////////////////////////////////////////////////////////////////////////

    // Nine weights that the PEs see the cycle after the write
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PE_NUM_ROW; i++) begin
                weights[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `PE_NUM_ROW; i++) begin
                for (int k = 0; k < `PE_NUM_COL; k++) begin
                    if (wr_hit[i][k]) begin
                        weights[i][k] <= cfg_wdata;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Flush command
    ////////////////////////////////////////////////////////////////////////////

    // Single cycle pulse that ignores the data word
    always_ff @(posedge clk) begin
        if (rst) begin
            flush <= 1'b0;
        end else begin
            flush <= flush_hit;
        end
    end

    // Nothing is mapped above the flush register
    cfg_addr_in_range: assert property (
        @(posedge clk) disable iff (rst)
        cfg_we |-> (cfg_addr <= pe_array_pkg::cfg_addr_t'(`PE_CFG_FLUSH_ADDR))
    ) else $error("config write to unmapped address %0d", cfg_addr);

endmodule

// File: design/row_bus_ctrl.sv
`timescale 1ns/1ps
`include "pe_array_consts.svh"

module row_bus_ctrl #(
    parameter int ROW_IDX = 0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   pix_valid,
    input  pe_array_pkg::tag_t     pix_tag,
    input  pe_array_pkg::pixel_t   pix_data,
    output logic [`PE_NUM_COL-1:0] accept,
    output logic [`PE_NUM_COL-1:0] win_full,
    output pe_array_pkg::pixel_t   bus_data
);

    // Highest ifmap row in a band
    localparam int MAX_TAG = `PE_NUM_ROW + `PE_NUM_COL - 2;
    // Older pixels a PE must hold before it can produce a sum
    localparam int WIN_DEPTH = `PE_NUM_COL - 1;

    logic               bus_valid;
    pe_array_pkg::tag_t bus_tag;
    logic [1:0]         acc_cnt [`PE_NUM_COL];

    ////////////////////////////////////////////////////////////////////////////
    // Input register stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_valid <= 1'b0;
            bus_tag   <= '0;
        end else begin
            bus_valid <= pix_valid;
            bus_tag   <= pix_tag;
        end
    end

    // Shared by all PEs of the row
    always_ff @(posedge clk) begin
        bus_data <= pix_data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tag match and window tracking
    ////////////////////////////////////////////////////////////////////////////

    // Column j of this row consumes ifmap row ROW_IDX + j
    always_comb begin
        for (int j = 0; j < `PE_NUM_COL; j++) begin
            accept[j] = bus_valid &&
                (bus_tag == pe_array_pkg::tag_t'(ROW_IDX + j));
        end
    end

    // Accepted pixels per column, saturates once the window is primed
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int j = 0; j < `PE_NUM_COL; j++) begin
                acc_cnt[j] <= '0;
            end
        end else begin
            for (int j = 0; j < `PE_NUM_COL; j++) begin
                if (accept[j] && (acc_cnt[j] != 2'(WIN_DEPTH))) begin
                    acc_cnt[j] <= acc_cnt[j] + 2'd1;
                end
            end
        end
    end

    // Current pixel completes a three tap window
    always_comb begin
        for (int j = 0; j < `PE_NUM_COL; j++) begin
            win_full[j] = accept[j] && (acc_cnt[j] == 2'(WIN_DEPTH));
        end
    end

    // Tags outside the band would never be consumed by any column
    tag_in_band: assert property (
        @(posedge clk) disable iff (rst)
        pix_valid |-> (pix_tag <= pe_array_pkg::tag_t'(MAX_TAG))
    ) else $error("ifmap tag %0d outside band", pix_tag);

endmodule

// File: design/conv_pe.sv
`timescale 1ns/1ps

module conv_pe (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      accept,
    input  logic                      win_full,
    input  pe_array_pkg::pixel_t      pix,
    input  pe_array_pkg::weight_row_t weights,
    input  pe_array_pkg::psum_t       psum_in,
    output pe_array_pkg::psum_t       psum_out,
    output logic                      psum_valid
);

    // Two most recent accepted pixels, win_old is the earlier one
    pe_array_pkg::pixel_t win_old;
    pe_array_pkg::pixel_t win_mid;

    pe_array_pkg::psum_t prod0;
    pe_array_pkg::psum_t prod1;
    pe_array_pkg::psum_t prod2;
    pe_array_pkg::psum_t mac_sum;
    logic                fire;

    ////////////////////////////////////////////////////////////////////////////
    // Sliding window
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            win_old <= '0;
            win_mid <= '0;
        end else if (accept) begin
            win_old <= win_mid;
            win_mid <= pix;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Multiply accumulate
    ////////////////////////////////////////////////////////////////////////////

    assign fire = accept && win_full;

    // Sign extend both operands to psum width before multiplying
    always_comb begin
        prod0 = pe_array_pkg::psum_t'(pe_array_pkg::pixel_t'(weights[0]))
              * pe_array_pkg::psum_t'(win_old);
        prod1 = pe_array_pkg::psum_t'(pe_array_pkg::pixel_t'(weights[1]))
              * pe_array_pkg::psum_t'(win_mid);
        prod2 = pe_array_pkg::psum_t'(pe_array_pkg::pixel_t'(weights[2]))
              * pe_array_pkg::psum_t'(pix);
        mac_sum = psum_in + prod0 + prod1 + prod2;
    end

    // Held until the next completed window, the PE above reads it later
    always_ff @(posedge clk) begin
        if (fire) begin
            psum_out <= mac_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            psum_valid <= 1'b0;
        end else begin
            psum_valid <= fire;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Row bus only marks a window full on a pixel this PE takes
    full_needs_accept: assert property (
        @(posedge clk) disable iff (rst)
        win_full |-> accept
    ) else $error("win_full raised without accept");

    // Pulse width is one cycle, since pixels enter one per cycle per row
    valid_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        psum_valid |=> !psum_valid
    );

endmodule

// File: design/pe_array.sv
`timescale 1ns/1ps
`include "pe_array_consts.svh"

module pe_array (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cfg_we,
    input  pe_array_pkg::cfg_addr_t   cfg_addr,
    input  pe_array_pkg::pixel_t      cfg_wdata,
    input  logic                      pix_valid,
    input  pe_array_pkg::tag_t        pix_tag,
    input  pe_array_pkg::pixel_t      pix_data,
    output logic                      out_valid,
    output logic [1:0]                out_col,
    output pe_array_pkg::psum_t       out_data
);

    pe_array_pkg::weight_row_t weights [`PE_NUM_ROW];
    logic                      flush;

    logic [`PE_NUM_COL-1:0] row_accept [`PE_NUM_ROW];
    logic [`PE_NUM_COL-1:0] row_full   [`PE_NUM_ROW];
    pe_array_pkg::pixel_t   row_pix    [`PE_NUM_ROW];

    pe_array_pkg::psum_t psum     [`PE_NUM_ROW][`PE_NUM_COL];
    pe_array_pkg::psum_t chain_in [`PE_NUM_ROW][`PE_NUM_COL];
    logic                psum_vld [`PE_NUM_ROW][`PE_NUM_COL];
    logic [`PE_NUM_COL-1:0] top_valid;

    pe_config_regs u_cfg (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .weights   (weights),
        .flush     (flush)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Row buses and PE grid
    ////////////////////////////////////////////////////////////////////////////

    genvar i, j;
    generate
        for (i = 0; i < `PE_NUM_ROW; i++) begin : g_row
            row_bus_ctrl #(.ROW_IDX(i)) u_bus (
                .clk       (clk),
                .rst       (rst),
                .flush     (flush),
                .pix_valid (pix_valid),
                .pix_tag   (pix_tag),
                .pix_data  (pix_data),
                .accept    (row_accept[i]),
                .win_full  (row_full[i]),
                .bus_data  (row_pix[i])
            );

            for (j = 0; j < `PE_NUM_COL; j++) begin : g_col
                // Psum enters at the bottom row with zero
                if (i == 0) begin : g_base
                    assign chain_in[i][j] = '0;
                end else begin : g_link
                    assign chain_in[i][j] = psum[i-1][j];
                end

                conv_pe u_pe (
                    .clk        (clk),
                    .rst        (rst),
                    .flush      (flush),
                    .accept     (row_accept[i][j]),
                    .win_full   (row_full[i][j]),
                    .pix        (row_pix[i]),
                    .weights    (weights[i]),
                    .psum_in    (chain_in[i][j]),
                    .psum_out   (psum[i][j]),
                    .psum_valid (psum_vld[i][j])
                );
            end
        end

        for (j = 0; j < `PE_NUM_COL; j++) begin : g_top
            assign top_valid[j] = psum_vld[`PE_NUM_ROW-1][j];
        end
    endgenerate

    ////////////////////////////////////////////////////////////////////////////
    // Output column select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        out_valid = 1'b0;
        out_col   = 2'd0;
        out_data  = psum[`PE_NUM_ROW-1][0];
        for (int c = 0; c < `PE_NUM_COL; c++) begin
            if (top_valid[c]) begin
                out_valid = 1'b1;
                out_col   = 2'(c);
                out_data  = psum[`PE_NUM_ROW-1][c];
            end
        end
    end

    // Tag ordering across the three row buses keeps the top row to one fire
    one_column_fires: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(top_valid)
    ) else $error("several columns fired together: %b", top_valid);

endmodule

// File: sim/pe_array_tb.sv
`timescale 1ns/1ps
`include "pe_array_consts.svh"

module pe_array_tb;

    logic                      clk;
    logic                      rst;
    logic                      cfg_we;
    pe_array_pkg::cfg_addr_t   cfg_addr;
    pe_array_pkg::pixel_t      cfg_wdata;
    logic                      pix_valid;
    pe_array_pkg::tag_t        pix_tag;
    pe_array_pkg::pixel_t      pix_data;
    logic                      out_valid;
    logic [1:0]                out_col;
    pe_array_pkg::psum_t       out_data;

    // Parsed trace records
    byte kind_q [$];
    int  arg_a_q [$];
    int  arg_b_q [$];

    // Expected outputs in arrival order
    // A due cycle of -1 skips the latency check
    int exp_col_q [$];
    int exp_val_q [$];
    int exp_due_q [$];

    int cycle_cnt = 0;
    int cycle_limit = 0;
    int last_pix_cycle = 0;
    bit gaps_on = 1'b0;
    int mismatches = 0;
    int unexpected_cnt = 0;
    int other_errs = 0;
    int e_col;
    int e_val;
    int e_due;

    pe_array DUT (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .pix_valid (pix_valid),
        .pix_tag   (pix_tag),
        .pix_data  (pix_data),
        .out_valid (out_valid),
        .out_col   (out_col),
        .out_data  (out_data)
    );

    always #20 clk = ~clk;

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    a;
        int    b;
        byte   kind;
        string line;
        fd = $fopen("sim/pe_array_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file sim/pe_array_trace.txt");
            other_errs++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                kind = line.getc(0);
                a = 0;
                b = 0;
                if (kind == "W" || kind == "F" || kind == "P" || kind == "E") begin
                    void'($sscanf(line.substr(1, line.len() - 1), "%d %d", a, b));
                    kind_q.push_back(kind);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(b);
                end
            end
            $fclose(fd);
        end
    endtask

    // Inputs change 1 ns after the edge and strobes last one cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        cfg_we    = 1'b0;
        pix_valid = 1'b0;
    endtask

    task automatic play_line(input byte kind, input int a, input int b);
        if (kind == "E") begin
            exp_col_q.push_back(a);
            exp_val_q.push_back(b);
            exp_due_q.push_back(gaps_on ? -1 : last_pix_cycle + 2);
        end else begin
            if (gaps_on) begin
                repeat ($urandom_range(3, 0)) next_cycle();
            end
            next_cycle();
            case (kind)
                "W": begin
                    cfg_we    = 1'b1;
                    cfg_addr  = pe_array_pkg::cfg_addr_t'(a);
                    cfg_wdata = pe_array_pkg::pixel_t'(b);
                end
                "F": begin
                    cfg_we    = 1'b1;
                    cfg_addr  = pe_array_pkg::cfg_addr_t'(`PE_CFG_FLUSH_ADDR);
                    cfg_wdata = '0;
                    // Second band runs with idle gaps
                    gaps_on   = 1'b1;
                end
                "P": begin
                    pix_valid      = 1'b1;
                    pix_tag        = pe_array_pkg::tag_t'(a);
                    pix_data       = pe_array_pkg::pixel_t'(b);
                    last_pix_cycle = cycle_cnt;
                end
                default: begin
                    other_errs++;
                end
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor sampled mid cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (exp_col_q.size() == 0) begin
                $display("Unexpected output at %0d ns on column %0d with value %0d",
                         $time, out_col, out_data);
                unexpected_cnt++;
            end else begin
                e_col = exp_col_q.pop_front();
                e_val = exp_val_q.pop_front();
                e_due = exp_due_q.pop_front();
                check_value("out_col", 32'(out_col), e_col);
                check_value("out_data", out_data, e_val);
                if (e_due >= 0) begin
                    check_value("out_valid cycle", cycle_cnt, e_due);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int drain_wait;
        clk       = 1'b0;
        rst       = 1'b1;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        pix_valid = 1'b0;
        pix_tag   = '0;
        pix_data  = '0;
        void'($urandom(32'h15b927b9));
        load_trace();
        cycle_limit = kind_q.size() * 4 + 16 + 50;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int idx = 0; idx < kind_q.size(); idx++) begin
            play_line(kind_q[idx], arg_a_q[idx], arg_b_q[idx]);
        end

        // Let the last pixels drain and then watch for stray outputs
        drain_wait = 0;
        while (exp_col_q.size() != 0 && drain_wait < 10) begin
            next_cycle();
            drain_wait++;
        end
        repeat (4) next_cycle();
        if (exp_col_q.size() != 0) begin
            $display("%0d expected outputs never appeared", exp_col_q.size());
            other_errs++;
        end

        $display("Summary: %0d value mismatches, %0d unexpected outputs, %0d other errors",
                 mismatches, unexpected_cnt, other_errs);
        if (mismatches == 0 && unexpected_cnt == 0 && other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sim/pe_array_trace.txt
# Columns: W addr data | F | P tag pixel | E column expected_psum
# Band 1 runs back to back, band 2 follows the flush with idle gaps
W 0 1
W 1 2
W 2 3
W 3 0
W 4 -1
W 5 4
W 6 2
W 7 0
W 8 -3
P 0 0
P 1 10
P 2 20
P 3 30
P 4 40
P 0 1
P 1 11
P 2 21
P 3 31
P 4 41
P 0 2
P 1 12
P 2 22
E 0 19
P 3 32
E 1 99
P 4 42
E 2 179
P 0 3
P 1 13
P 2 23
E 0 27
P 3 33
E 1 107
P 4 43
E 2 187
P 0 4
P 1 14
P 2 24
E 0 35
P 3 34
E 1 115
P 4 44
E 2 195
P 0 5
P 1 15
P 2 25
E 0 43
P 3 35
E 1 123
P 4 45
E 2 203
F
W 0 -300
W 1 250
W 2 7
W 3 1000
W 4 -2
W 5 -450
W 6 3
W 7 -999
W 8 120
P 0 1200
P 1 -800
P 2 5
P 3 999
P 4 -250
P 0 -35
P 1 17
P 2 -1500
P 3 -1
P 4 4000
P 0 64
P 1 2000
P 2 300
E 0 -533821
P 3 -640
E 1 58446
P 4 11
E 2 -3082828

// File: all.f
+incdir+design
design/pe_array_pkg.sv
design/pe_config_regs.sv
design/row_bus_ctrl.sv
design/conv_pe.sv
design/pe_array.sv
sim/pe_array_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pe_array testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim_run.log

verilator --binary --timing --assert -f all.f --top-module pe_array_tb -o pe_array_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pe_array_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation passed"
exit 0
